//--- bench/eeprom_device_model.sv
module eeprom_device_model (
    input  logic CLK,
    input  logic scl,
    input  logic sda_out,
    input  logic sda_oe,
    output logic sda_in
);

    eeprom_bus_pkg::data_t mem [0:(1 << eeprom_bus_pkg::addr_w) - 1];
    eeprom_bus_pkg::addr_t addr;
    eeprom_bus_pkg::data_t rx_byte;
    eeprom_bus_pkg::data_t rx_next;
    eeprom_bus_pkg::data_t tx_byte;
    eeprom_bus_pkg::data_t wbyte;
    logic [2:0]            rx_cnt;
    logic [1:0]            byte_idx;
    logic [3:0]            tx_cnt;
    logic                  sending;
    logic                  have_data;
    logic                  prev_scl;
    logic                  prev_sda;
    logic                  sda_line;

    assign sda_line = sda_oe ? sda_out : 1'b1;   // released line reads high
    assign rx_next  = {rx_byte[6:0], sda_line};

    initial
    begin
        for (int i = 0; i < (1 << eeprom_bus_pkg::addr_w); i++)
            mem[i] = i[7:0] ^ eeprom_bus_pkg::init_byte_mask;
        prev_scl  = 1'b0;
        prev_sda  = 1'b1;
        sda_in    = 1'b1;
        sending   = 1'b0;
        have_data = 1'b0;
        rx_cnt    = 3'd0;
        byte_idx  = 2'd0;
    end

    // bus values sampled mid cycle, after the master's edge
    always @(negedge CLK)
    begin
        if (!prev_scl && scl && prev_sda && !sda_line)
        begin
            rx_cnt    <= 3'd0;         // start or repeated start
            byte_idx  <= 2'd0;
            sending   <= 1'b0;
            have_data <= 1'b0;
        end
        else if (!prev_scl && scl && !prev_sda && sda_line)
        begin
            if (have_data)
                mem[addr] <= wbyte;   // write lands at stop
            have_data <= 1'b0;
            sending   <= 1'b0;
            sda_in    <= 1'b1;
        end
        else if (!prev_scl && scl && !sending)
        begin
            rx_byte <= rx_next;
            rx_cnt  <= rx_cnt + 3'd1;
            if (rx_cnt == 3'd7)
            begin
                case (byte_idx)
                    2'd0:
                        if (rx_next[7:4] == eeprom_bus_pkg::dev_code && rx_next[0])
                        begin
                            sending <= 1'b1;
                            tx_byte <= mem[addr];
                            tx_cnt  <= 4'd0;
                        end
                        else if (rx_next[7:4] == eeprom_bus_pkg::dev_code)
                        begin
                            addr[10:8] <= rx_next[3:1];
                            byte_idx   <= 2'd1;
                        end
                    2'd1:
                    begin
                        addr[7:0] <= rx_next;
                        byte_idx  <= 2'd2;
                    end
                    2'd2:
                    begin
                        wbyte     <= rx_next;
                        have_data <= 1'b1;
                        byte_idx  <= 2'd3;
                    end
                    default: ;
                endcase
            end
        end
        else if (prev_scl && !scl && sending)
        begin
            // next data bit goes out while scl is low
            if (tx_cnt < 4'd8)
                sda_in <= tx_byte[3'd7 - tx_cnt[2:0]];
            else
            begin
                sda_in  <= 1'b1;
                sending <= 1'b0;
            end
            tx_cnt <= tx_cnt + 4'd1;
        end
        prev_scl <= scl;
        prev_sda <= sda_line;
    end

endmodule

//--- bench/eeprom_sva.sv
module eeprom_sva (
    input logic                        CLK,
    input logic                        RESET,
    input logic                        scl,
    input logic                        sda_out,
    input logic                        sda_oe,
    input logic                        a_busy,
    input logic                        a_done,
    input logic                        b_busy,
    input logic                        b_done,
    input eeprom_fsm_pkg::main_state_t main_state
);

    logic sda_v;

    assign sda_v = sda_oe ? sda_out : 1'b1;

    // sda moving with scl high is a start or a stop
    assert property (@(posedge CLK) disable iff (RESET)
        (scl && sda_v != $past(sda_v)) |->
            ($past(main_state) == eeprom_fsm_pkg::write_start ||
             $past(main_state) == eeprom_fsm_pkg::read_start ||
             $past(main_state) == eeprom_fsm_pkg::stop))
        else $error("sda changed with scl high outside start or stop");

    assert property (@(posedge CLK) disable iff (RESET) a_done |=> !a_done)
        else $error("a_done longer than one cycle");
    assert property (@(posedge CLK) disable iff (RESET) b_done |=> !b_done)
        else $error("b_done longer than one cycle");
    assert property (@(posedge CLK) disable iff (RESET) $fell(a_busy) |-> a_done)
        else $error("a_busy fell without a_done");
    assert property (@(posedge CLK) disable iff (RESET) $fell(b_busy) |-> b_done)
        else $error("b_busy fell without b_done");

endmodule

bind eeprom_top eeprom_sva sva (
    .CLK(CLK), .RESET(RESET), .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe),
    .a_busy(a_busy), .a_done(a_done), .b_busy(b_busy), .b_done(b_done),
    .main_state(engine.main_state)
);

//--- bench/tb_eeprom_top.sv
module tb_eeprom_top;

    localparam int n_ops      = 200;
    localparam int max_cycles = n_ops * 2 * 150;

    logic                  CLK;
    logic                  RESET;
    logic                  a_wr;
    logic                  a_rd;
    eeprom_bus_pkg::addr_t a_addr;
    eeprom_bus_pkg::data_t a_wdata;
    logic                  a_busy;
    logic                  a_done;
    eeprom_bus_pkg::data_t a_rdata;
    logic                  b_wr;
    logic                  b_rd;
    eeprom_bus_pkg::addr_t b_addr;
    eeprom_bus_pkg::data_t b_wdata;
    logic                  b_busy;
    logic                  b_done;
    eeprom_bus_pkg::data_t b_rdata;
    logic                  scl;
    logic                  sda_out;
    logic                  sda_oe;
    logic                  sda_in;

    eeprom_bus_pkg::data_t ref_mem [0:(1 << eeprom_bus_pkg::addr_w) - 1];
    logic                  pend_valid [2];
    logic                  pend_rd [2];
    eeprom_bus_pkg::addr_t pend_addr [2];
    eeprom_bus_pkg::data_t pend_data [2];
    logic [31:0]           rng;
    logic [31:0]           r;
    int                    cycles;
    int                    rnd_ops;
    int                    last_port;
    logic                  other_waiting;

    eeprom_top dut (
        .CLK(CLK), .RESET(RESET),
        .a_wr(a_wr), .a_rd(a_rd), .a_addr(a_addr), .a_wdata(a_wdata),
        .a_busy(a_busy), .a_done(a_done), .a_rdata(a_rdata),
        .b_wr(b_wr), .b_rd(b_rd), .b_addr(b_addr), .b_wdata(b_wdata),
        .b_busy(b_busy), .b_done(b_done), .b_rdata(b_rdata),
        .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe), .sda_in(sda_in)
    );

    eeprom_device_model dev (
        .CLK(CLK), .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe), .sda_in(sda_in)
    );

    initial
    begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles == max_cycles)
        begin
            $display("timeout: traffic did not finish within %0d cycles", max_cycles);
            $display("SOME TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    task automatic check_eq(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected %h actual %h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    function automatic logic port_busy(input int p);
        return (p == 0) ? a_busy : b_busy;
    endfunction

    task automatic strobe(input int p, input logic w, input logic rd,
                          input eeprom_bus_pkg::addr_t ad, input eeprom_bus_pkg::data_t d);
        if (p == 0)
        begin
            a_wr    = w;
            a_rd    = rd;
            a_addr  = ad;
            a_wdata = d;
        end
        else
        begin
            b_wr    = w;
            b_rd    = rd;
            b_addr  = ad;
            b_wdata = d;
        end
    endtask

    task automatic issue(input int p, input logic w, input logic rd,
                         input eeprom_bus_pkg::addr_t ad, input eeprom_bus_pkg::data_t d);
        strobe(p, w, rd, ad, d);
        pend_valid[p] = 1'b1;
        pend_rd[p]    = !w;      // wr wins when both are set
        pend_addr[p]  = ad;
        pend_data[p]  = d;
    endtask

    task automatic collect_done(input int p);
        if ((p == 0) ? a_done : b_done)
        begin
            check_eq((p == 0) ? "a_done" : "b_done", pend_valid[p], 1'b1);
            // a waiting peer gets the next turn
            if (last_port >= 0 && other_waiting)
                check_eq("done port", 1 - last_port, p);
            other_waiting = port_busy(1 - p);
            last_port     = p;
            if (pend_rd[p])
                check_eq((p == 0) ? "a_rdata" : "b_rdata", ref_mem[pend_addr[p]],
                         (p == 0) ? a_rdata : b_rdata);
            else
                ref_mem[pend_addr[p]] = pend_data[p];
            pend_valid[p] = 1'b0;
        end
    endtask

    task automatic tick();
        @(posedge CLK);
        #1;
        strobe(0, 1'b0, 1'b0, '0, '0);
        strobe(1, 1'b0, 1'b0, '0, '0);
        collect_done(0);
        collect_done(1);
    endtask

    task automatic wait_idle();
        while (pend_valid[0] || pend_valid[1])
            tick();
    endtask

    initial
    begin
        for (int i = 0; i < (1 << eeprom_bus_pkg::addr_w); i++)
            ref_mem[i] = i[7:0] ^ eeprom_bus_pkg::init_byte_mask;
        rng           = 32'hc728_09f4;
        cycles        = 0;
        rnd_ops       = 0;
        last_port     = -1;
        other_waiting = 1'b0;
        pend_valid[0] = 1'b0;
        pend_valid[1] = 1'b0;
        strobe(0, 1'b0, 1'b0, '0, '0);
        strobe(1, 1'b0, 1'b0, '0, '0);
        RESET = 1'b1;
        repeat (4) @(posedge CLK);
        #1;
        RESET = 1'b0;

        tick();
        tick();
        check_eq("a_busy", 0, a_busy);
        check_eq("b_busy", 0, b_busy);
        check_eq("a_done", 0, a_done);
        check_eq("b_done", 0, b_done);
        check_eq("sda_oe", 0, sda_oe);
        check_eq("scl", 0, scl);

        issue(0, 1'b0, 1'b1, 11'h3c5, 8'h00);
        wait_idle();
        check_eq("a_rdata", 8'hc5 ^ eeprom_bus_pkg::init_byte_mask, a_rdata);
        issue(0, 1'b1, 1'b0, 11'h3c5, 8'ha7);
        wait_idle();
        issue(0, 1'b0, 1'b1, 11'h3c5, 8'h00);
        wait_idle();
        check_eq("a_rdata", 8'ha7, a_rdata);

        // strobes into a busy port must be dropped
        issue(1, 1'b1, 1'b0, 11'h105, 8'h3e);
        tick();
        strobe(1, 1'b0, 1'b1, 11'h105, 8'hff);
        tick();
        strobe(1, 1'b1, 1'b0, 11'h105, 8'h11);
        wait_idle();
        issue(1, 1'b0, 1'b1, 11'h105, 8'h00);
        wait_idle();
        check_eq("b_rdata", 8'h3e, b_rdata);

        issue(0, 1'b1, 1'b1, 11'h7f0, 8'h5c);
        issue(1, 1'b0, 1'b1, 11'h7f0, 8'h00);
        wait_idle();
        check_eq("b_rdata", 8'h5c, b_rdata);   // a goes first since b was served last

        while (rnd_ops < n_ops)
        begin
            tick();
            for (int p = 0; p < 2; p++)
            begin
                rng = xorshift32(rng);
                r   = rng;
                if (!pend_valid[p] && r[1:0] != 2'd0 && rnd_ops < n_ops)
                begin
                    rng = xorshift32(rng);
                    issue(p, r[3:2] == 2'd0 || r[3:2] == 2'd3, r[3:2] != 2'd0,
                          rng[10:0] & 11'h70f, rng[23:16]);
                    rnd_ops++;
                end
                else if (pend_valid[p] && r[5:2] == 4'd0)
                    strobe(p, r[6], !r[6], r[20:10], r[31:24]);
            end
        end
        wait_idle();
        repeat (8) tick();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- flist.f
logic/eeprom_bus_pkg.sv
logic/eeprom_fsm_pkg.sv
logic/eeprom_wr.sv
logic/req_slot.sv
logic/bus_arbiter.sv
logic/eeprom_top.sv
bench/eeprom_device_model.sv
bench/eeprom_sva.sv
bench/tb_eeprom_top.sv

//--- logic/bus_arbiter.sv
module bus_arbiter (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  req_a,
    input  logic                  req_rd_a,
    input  eeprom_bus_pkg::addr_t req_addr_a,
    input  eeprom_bus_pkg::data_t req_wdata_a,
    input  logic                  req_b,
    input  logic                  req_rd_b,
    input  eeprom_bus_pkg::addr_t req_addr_b,
    input  eeprom_bus_pkg::data_t req_wdata_b,
    output logic                  grant_done_a,
    output logic                  grant_done_b,
    output logic                  eng_wr,
    output logic                  eng_rd,
    output eeprom_bus_pkg::addr_t eng_addr,
    output eeprom_bus_pkg::data_t eng_wdata,
    input  logic                  eng_ack
);

    eeprom_fsm_pkg::arb_state_t state;

    logic last_b;     // b got the bus last
    logic want_a;
    logic want_b;

    // the served slot still shows req during its grant_done cycle
    assign want_a = req_a && !grant_done_a;
    assign want_b = req_b && !grant_done_b;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state        <= eeprom_fsm_pkg::arb_idle;
            last_b       <= 1'b0;
            grant_done_a <= 1'b0;
            grant_done_b <= 1'b0;
        end
        else
        begin
            grant_done_a <= 1'b0;
            grant_done_b <= 1'b0;
            case (state)
                eeprom_fsm_pkg::arb_idle:
                    if (want_a && (!want_b || last_b))
                        state <= eeprom_fsm_pkg::serve_a;
                    else if (want_b)
                        state <= eeprom_fsm_pkg::serve_b;
                eeprom_fsm_pkg::serve_a:
                    if (eng_ack)
                    begin
                        grant_done_a <= 1'b1;
                        last_b       <= 1'b0;
                        state        <= eeprom_fsm_pkg::arb_idle;
                    end
                eeprom_fsm_pkg::serve_b:
                    if (eng_ack)
                    begin
                        grant_done_b <= 1'b1;
                        last_b       <= 1'b1;
                        state        <= eeprom_fsm_pkg::arb_idle;
                    end
                default: state <= eeprom_fsm_pkg::arb_idle;
            endcase
        end
    end

    // request levels follow the grant, dropped once back in idle
    always_comb
    begin
        eng_wr    = 1'b0;
        eng_rd    = 1'b0;
        eng_addr  = req_addr_a;
        eng_wdata = req_wdata_a;
        case (state)
            eeprom_fsm_pkg::serve_a:
            begin
                eng_wr = !req_rd_a;
                eng_rd = req_rd_a;
            end
            eeprom_fsm_pkg::serve_b:
            begin
                eng_wr    = !req_rd_b;
                eng_rd    = req_rd_b;
                eng_addr  = req_addr_b;
                eng_wdata = req_wdata_b;
            end
            default: ;
        endcase
    end

endmodule

//--- logic/eeprom_bus_pkg.sv
package eeprom_bus_pkg;

    // byte address of the serial part
    localparam int addr_w = 11;
    localparam int data_w = 8;

    // device code width in the control byte
    localparam int dev_w = 4;

    typedef logic [addr_w-1:0] addr_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [dev_w-1:0]  dev_code_t;

    // control byte {dev_code, addr[10:8], read bit}
    typedef logic [data_w-1:0] ctrl_t;

    localparam dev_code_t dev_code = 4'b1010;

    // power-up contents are addr[7:0] ^ mask
    localparam data_t init_byte_mask = 8'h5A;

endpackage

//--- logic/eeprom_fsm_pkg.sv
package eeprom_fsm_pkg;

    // frame sequence of the serial engine
    typedef enum logic [3:0] {
        idle,
        ready,
        write_start,
        ctrl_write,
        addr_write,
        data_write,
        read_start,
        ctrl_read,
        data_read,
        stop,
        ackn
    } main_state_t;

    // one bit slot is a drive edge (scl falls) then a clock edge (scl rises)
    typedef enum logic [1:0] {
        sh_idle,
        sh_drive,
        sh_clock
    } shift_state_t;

    typedef enum logic [1:0] {
        arb_idle,
        serve_a,
        serve_b
    } arb_state_t;

endpackage

//--- logic/eeprom_top.sv
module eeprom_top (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  a_wr,
    input  logic                  a_rd,
    input  eeprom_bus_pkg::addr_t a_addr,
    input  eeprom_bus_pkg::data_t a_wdata,
    output logic                  a_busy,
    output logic                  a_done,
    output eeprom_bus_pkg::data_t a_rdata,
    input  logic                  b_wr,
    input  logic                  b_rd,
    input  eeprom_bus_pkg::addr_t b_addr,
    input  eeprom_bus_pkg::data_t b_wdata,
    output logic                  b_busy,
    output logic                  b_done,
    output eeprom_bus_pkg::data_t b_rdata,
    output logic                  scl,
    output logic                  sda_out,
    output logic                  sda_oe,
    input  logic                  sda_in
);

    logic                  a_req;
    logic                  a_req_rd;
    eeprom_bus_pkg::addr_t a_req_addr;
    eeprom_bus_pkg::data_t a_req_wdata;
    logic                  a_grant_done;
    logic                  b_req;
    logic                  b_req_rd;
    eeprom_bus_pkg::addr_t b_req_addr;
    eeprom_bus_pkg::data_t b_req_wdata;
    logic                  b_grant_done;
    logic                  eng_wr;
    logic                  eng_rd;
    eeprom_bus_pkg::addr_t eng_addr;
    eeprom_bus_pkg::data_t eng_wdata;
    logic                  eng_ack;
    eeprom_bus_pkg::data_t eng_rdata;    // shared by both slots

    req_slot slot_a (
        .CLK(CLK), .RESET(RESET),
        .wr(a_wr), .rd(a_rd), .addr(a_addr), .wdata(a_wdata),
        .busy(a_busy), .done(a_done), .rdata(a_rdata),
        .req(a_req), .req_rd(a_req_rd), .req_addr(a_req_addr), .req_wdata(a_req_wdata),
        .grant_done(a_grant_done), .bus_rdata(eng_rdata)
    );

    req_slot slot_b (
        .CLK(CLK), .RESET(RESET),
        .wr(b_wr), .rd(b_rd), .addr(b_addr), .wdata(b_wdata),
        .busy(b_busy), .done(b_done), .rdata(b_rdata),
        .req(b_req), .req_rd(b_req_rd), .req_addr(b_req_addr), .req_wdata(b_req_wdata),
        .grant_done(b_grant_done), .bus_rdata(eng_rdata)
    );

    bus_arbiter arbiter (
        .CLK(CLK), .RESET(RESET),
        .req_a(a_req), .req_rd_a(a_req_rd), .req_addr_a(a_req_addr), .req_wdata_a(a_req_wdata),
        .req_b(b_req), .req_rd_b(b_req_rd), .req_addr_b(b_req_addr), .req_wdata_b(b_req_wdata),
        .grant_done_a(a_grant_done), .grant_done_b(b_grant_done),
        .eng_wr(eng_wr), .eng_rd(eng_rd), .eng_addr(eng_addr), .eng_wdata(eng_wdata),
        .eng_ack(eng_ack)
    );

    eeprom_wr engine (
        .CLK(CLK), .RESET(RESET),
        .wr(eng_wr), .rd(eng_rd), .addr(eng_addr), .wdata(eng_wdata),
        .ack(eng_ack), .rdata(eng_rdata),
        .scl(scl), .sda_out(sda_out), .sda_oe(sda_oe), .sda_in(sda_in)
    );

endmodule

//--- logic/eeprom_wr.sv
module eeprom_wr (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_bus_pkg::addr_t addr,
    input  eeprom_bus_pkg::data_t wdata,
    output logic                  ack,
    output eeprom_bus_pkg::data_t rdata,
    output logic                  scl,
    output logic                  sda_out,
    output logic                  sda_oe,
    input  logic                  sda_in
);

    eeprom_fsm_pkg::main_state_t  main_state;
    eeprom_fsm_pkg::shift_state_t shift_state;

    eeprom_bus_pkg::data_t shreg;     // byte going out, msb first
    eeprom_bus_pkg::data_t next_byte;
    logic [2:0]            bit_cnt;
    logic                  wf;
    logic                  rf;
    logic                  phase_done;
    logic                  is_start;
    logic                  is_stop;
    logic                  is_byte_in;

    function automatic eeprom_bus_pkg::ctrl_t ctrl_byte(
        input eeprom_bus_pkg::addr_t a,
        input logic                  read_bit
    );
        return {eeprom_bus_pkg::dev_code, a[eeprom_bus_pkg::addr_w-1:8], read_bit};
    endfunction

    assign is_start   = (main_state == eeprom_fsm_pkg::write_start) ||
                        (main_state == eeprom_fsm_pkg::read_start);
    assign is_stop    = (main_state == eeprom_fsm_pkg::stop);
    assign is_byte_in = (main_state == eeprom_fsm_pkg::data_read);

    // last clock edge of the current sub-sequence
    assign phase_done = (shift_state == eeprom_fsm_pkg::sh_clock) && (bit_cnt == 3'd0);

    // byte for the phase that follows the current one
    always_comb
    begin
        case (main_state)
            eeprom_fsm_pkg::write_start: next_byte = ctrl_byte(addr, 1'b0);
            eeprom_fsm_pkg::ctrl_write:  next_byte = addr[7:0];
            eeprom_fsm_pkg::read_start:  next_byte = ctrl_byte(addr, 1'b1);
            default:                     next_byte = wdata;
        endcase
    end

    // half rate serial clock, parked low in idle
    always_ff @(posedge CLK)
    begin
        if (RESET || main_state == eeprom_fsm_pkg::idle)
            scl <= 1'b0;
        else
            scl <= ~scl;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            main_state  <= eeprom_fsm_pkg::idle;
            shift_state <= eeprom_fsm_pkg::sh_idle;
            bit_cnt     <= 3'd0;
            wf          <= 1'b0;
            rf          <= 1'b0;
            ack         <= 1'b0;
            sda_out     <= 1'b1;
            sda_oe      <= 1'b0;
        end
        else
        begin
            // bit slot walker shared by start, byte out, byte in and stop
            case (shift_state)
                eeprom_fsm_pkg::sh_drive:
                begin
                    sda_oe <= !is_byte_in;    // release for read data
                    if (is_start)
                        sda_out <= 1'b1;
                    else if (is_stop)
                        sda_out <= 1'b0;
                    else if (!is_byte_in)
                        sda_out <= shreg[7];
                    shift_state <= eeprom_fsm_pkg::sh_clock;
                end
                eeprom_fsm_pkg::sh_clock:
                begin
                    if (is_start)
                        sda_out <= 1'b0;      // falls as scl rises
                    else if (is_stop)
                        sda_out <= 1'b1;      // rises as scl rises
                    bit_cnt     <= bit_cnt - 3'd1;
                    shift_state <= eeprom_fsm_pkg::sh_drive;
                end
                default: ;
            endcase

            // frame sequence, later assignments override the walker
            case (main_state)
                eeprom_fsm_pkg::idle:
                    if (wr || rd)
                    begin
                        wf         <= wr;
                        rf         <= rd && !wr;   // wr wins
                        sda_oe     <= 1'b1;
                        sda_out    <= 1'b1;
                        main_state <= eeprom_fsm_pkg::ready;
                    end
                eeprom_fsm_pkg::ready:
                begin
                    shift_state <= eeprom_fsm_pkg::sh_drive;
                    bit_cnt     <= 3'd0;
                    main_state  <= eeprom_fsm_pkg::write_start;
                end
                eeprom_fsm_pkg::write_start:
                    if (phase_done)
                    begin
                        bit_cnt    <= 3'd7;
                        main_state <= eeprom_fsm_pkg::ctrl_write;
                    end
                eeprom_fsm_pkg::ctrl_write:
                    if (phase_done)
                    begin
                        bit_cnt    <= 3'd7;
                        main_state <= eeprom_fsm_pkg::addr_write;
                    end
                eeprom_fsm_pkg::addr_write:
                    if (phase_done)
                    begin
                        if (wf)
                        begin
                            bit_cnt    <= 3'd7;
                            main_state <= eeprom_fsm_pkg::data_write;
                        end
                        else
                        begin
                            bit_cnt    <= 3'd0;    // repeated start
                            main_state <= eeprom_fsm_pkg::read_start;
                        end
                    end
                eeprom_fsm_pkg::data_write:
                    if (phase_done)
                    begin
                        bit_cnt    <= 3'd0;
                        main_state <= eeprom_fsm_pkg::stop;
                    end
                eeprom_fsm_pkg::read_start:
                    if (phase_done)
                    begin
                        bit_cnt    <= 3'd7;
                        main_state <= eeprom_fsm_pkg::ctrl_read;
                    end
                eeprom_fsm_pkg::ctrl_read:
                    if (phase_done)
                    begin
                        bit_cnt    <= 3'd7;
                        main_state <= eeprom_fsm_pkg::data_read;
                    end
                eeprom_fsm_pkg::data_read:
                    if (phase_done)
                    begin
                        bit_cnt    <= 3'd0;
                        main_state <= eeprom_fsm_pkg::stop;
                    end
                eeprom_fsm_pkg::stop:
                    if (phase_done)
                    begin
                        shift_state <= eeprom_fsm_pkg::sh_idle;
                        ack         <= 1'b1;
                        main_state  <= eeprom_fsm_pkg::ackn;
                    end
                eeprom_fsm_pkg::ackn:
                begin
                    ack        <= 1'b0;
                    wf         <= 1'b0;
                    rf         <= 1'b0;
                    sda_oe     <= 1'b0;
                    main_state <= eeprom_fsm_pkg::idle;
                end
                default: main_state <= eeprom_fsm_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (phase_done)
            shreg <= next_byte;
        else if (shift_state == eeprom_fsm_pkg::sh_drive && !is_byte_in)
            shreg <= {shreg[6:0], 1'b0};

        // sampled at the end of each scl high cycle, bit 0 lands on the stop's drive edge
        if (rf && (is_byte_in || is_stop) && shift_state == eeprom_fsm_pkg::sh_drive)
            rdata <= {rdata[6:0], sda_in};
    end

endmodule

//--- logic/req_slot.sv
module req_slot (
    input  logic                  CLK,
    input  logic                  RESET,
    input  logic                  wr,
    input  logic                  rd,
    input  eeprom_bus_pkg::addr_t addr,
    input  eeprom_bus_pkg::data_t wdata,
    output logic                  busy,
    output logic                  done,
    output eeprom_bus_pkg::data_t rdata,
    output logic                  req,
    output logic                  req_rd,
    output eeprom_bus_pkg::addr_t req_addr,
    output eeprom_bus_pkg::data_t req_wdata,
    input  logic                  grant_done,
    input  eeprom_bus_pkg::data_t bus_rdata
);

    logic accept;

    assign accept = (wr || rd) && !busy;  // strobes while busy are dropped
    assign req    = busy;                 // pending until done

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy <= 1'b0;
            done <= 1'b0;
        end
        else
        begin
            done <= grant_done;
            if (grant_done)
                busy <= 1'b0;
            else if (accept)
                busy <= 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req_rd    <= !wr;     // wr wins over rd
            req_addr  <= addr;
            req_wdata <= wdata;
        end
        if (grant_done)
            rdata <= bus_rdata;
    end

endmodule

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_eeprom_top -f flist.f -o sim_eeprom
./obj_dir/sim_eeprom > sim.log 2>&1 || true
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log || ! grep -q "ALL TESTS PASSED" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"
